// ==== verilog/riscv_isa_pkg.sv ====
package riscv_isa_pkg;

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        op_load   = 7'b0000011, // lw
        op_store  = 7'b0100011, // sw
        op_imm    = 7'b0010011, // addi .. srai
        op_reg    = 7'b0110011, // add .. and
        op_branch = 7'b1100011, // beq .. bgeu
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111
    } opcode_e;

    // immediate layouts the extender knows about
    typedef enum logic [2:0] {
        imm_src_itype = 3'd0,
        imm_src_stype = 3'd1,
        imm_src_btype = 3'd2,
        imm_src_jtype = 3'd3
    } imm_src_e;

    // funct3 of conditional branches
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // funct3 of op / op-imm
    localparam logic [2:0] f3_add  = 3'b000; // add, sub, addi
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_sr   = 3'b101; // srl/sra, split by instr[30]
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

endpackage

// ==== verilog/riscv_ctrl_pkg.sv ====
package riscv_ctrl_pkg;

    // operations the alu understands
    typedef enum logic [3:0] {
        alu_add  = 4'd0,
        alu_sub  = 4'd1,
        alu_and  = 4'd2,
        alu_or   = 4'd3,
        alu_xor  = 4'd4,
        alu_slt  = 4'd5, // signed compare
        alu_sltu = 4'd6, // unsigned compare
        alu_sll  = 4'd7,
        alu_srl  = 4'd8,
        alu_sra  = 4'd9
    } alu_op_e;

    // alu operand b
    typedef enum logic [1:0] {
        alu_src_reg     = 2'd0, // rs2
        alu_src_ext_imm = 2'd1  // sign-extended immediate
    } alu_src_e;

    // register write-back value
    typedef enum logic [1:0] {
        res_src_alu_out   = 2'd0,
        res_src_read_data = 2'd1, // loads
        res_src_pc_plus_4 = 2'd2  // link for jal/jalr
    } res_src_e;

    // next pc
    typedef enum logic [1:0] {
        pc_src_plus_4       = 2'd0,
        pc_src_plus_off     = 2'd1, // taken branch, jal
        pc_src_reg_plus_off = 2'd2  // jalr
    } pc_src_e;

    // bit positions in alu_flags
    localparam int unsigned flag_n = 3;
    localparam int unsigned flag_z = 2;
    localparam int unsigned flag_c = 1;
    localparam int unsigned flag_v = 0;

    localparam logic [31:0] reset_pc = 32'h0000_0000; // first fetch address

endpackage

// ==== verilog/control_decoder.sv ====
`timescale 1ns/1ps

module control_decoder import riscv_isa_pkg::*, riscv_ctrl_pkg::*; (
    input  logic [31:0] instr,
    input  logic [3:0]  alu_flags,
    output logic        reg_we,
    output logic        mem_we,
    output imm_src_e    imm_src,
    output alu_op_e     alu_ctrl,
    output alu_src_e    alu_src,
    output res_src_e    result_src,
    output pc_src_e     pc_src
);
    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt_op;       // funct7 bit 30
    logic       branch_taken;
    alu_op_e    arith_op;     // op for op / op-imm

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign alt_op = instr[30];

    // funct3 to alu op, bit 30 picks sub (reg only) and sra
    always_comb begin
        case (funct3)
            f3_add:  arith_op = (opcode == op_reg && alt_op) ? alu_sub : alu_add;
            f3_sll:  arith_op = alu_sll;
            f3_slt:  arith_op = alu_slt;
            f3_sltu: arith_op = alu_sltu;
            f3_xor:  arith_op = alu_xor;
            f3_sr:   arith_op = alt_op ? alu_sra : alu_srl; // srai has bit 30 set too
            f3_or:   arith_op = alu_or;
            f3_and:  arith_op = alu_and;
            default: arith_op = alu_add;
        endcase
    end

    // condition on flags of rs1 - rs2
    always_comb begin
        case (funct3)
            f3_beq:  branch_taken = alu_flags[flag_z];
            f3_bne:  branch_taken = !alu_flags[flag_z];
            f3_blt:  branch_taken = alu_flags[flag_n] ^ alu_flags[flag_v];
            f3_bge:  branch_taken = !(alu_flags[flag_n] ^ alu_flags[flag_v]);
            f3_bltu: branch_taken = !alu_flags[flag_c]; // borrow
            f3_bgeu: branch_taken = alu_flags[flag_c];
            default: branch_taken = 1'b0; // 010/011 not a branch
        endcase
    end

    always_comb begin
        // safe defaults, nothing written
        reg_we     = 1'b0;
        mem_we     = 1'b0;
        imm_src    = imm_src_itype;
        alu_ctrl   = alu_add;
        alu_src    = alu_src_reg;
        result_src = res_src_alu_out;
        pc_src     = pc_src_plus_4;
        case (opcode)
            op_load: begin
                reg_we     = 1'b1;
                alu_src    = alu_src_ext_imm; // rs1 + imm
                result_src = res_src_read_data;
            end
            op_store: begin
                mem_we  = 1'b1;
                imm_src = imm_src_stype;
                alu_src = alu_src_ext_imm;
            end
            op_imm: begin
                reg_we   = 1'b1;
                alu_ctrl = arith_op;
                alu_src  = alu_src_ext_imm;
            end
            op_reg: begin
                reg_we   = 1'b1;
                alu_ctrl = arith_op;
            end
            op_branch: begin
                imm_src  = imm_src_btype;
                alu_ctrl = alu_sub; // flags only
                pc_src   = branch_taken ? pc_src_plus_off : pc_src_plus_4;
            end
            op_jal: begin
                reg_we     = 1'b1;
                imm_src    = imm_src_jtype;
                result_src = res_src_pc_plus_4; // link
                pc_src     = pc_src_plus_off;
            end
            op_jalr: begin
                reg_we     = 1'b1;
                result_src = res_src_pc_plus_4;
                pc_src     = pc_src_reg_plus_off;
            end
            default: ; // unsupported, keep defaults
        endcase
    end

endmodule

// ==== verilog/imm_extend.sv ====
`timescale 1ns/1ps

module imm_extend import riscv_isa_pkg::*; (
    input  logic [31:0] instr,
    input  imm_src_e    imm_src,
    output logic [31:0] ext_imm
);
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;

    // sign bit always instr[31]
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};

    // b and j are byte offsets, bit 0 implied zero
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                    instr[11:8], 1'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                    instr[30:21], 1'b0};

    always_comb begin
        case (imm_src)
            imm_src_itype: ext_imm = imm_i; // loads, op-imm, jalr
            imm_src_stype: ext_imm = imm_s;
            imm_src_btype: ext_imm = imm_b;
            imm_src_jtype: ext_imm = imm_j;
            default:       ext_imm = 32'h0;
        endcase
    end

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

module regfile (
    input  logic        clk,
    input  logic [4:0]  addr1,  // rs1
    input  logic [4:0]  addr2,  // rs2
    input  logic [4:0]  addr3,  // rd
    input  logic [31:0] wd3,
    input  logic        we,
    output logic [31:0] rd1,
    output logic [31:0] rd2
);
    logic [31:0] regs [32]; // x0 entry never written

    always_ff @(posedge clk) begin
        if (we && addr3 != 5'd0) begin
            regs[addr3] <= wd3;
        end
    end

    // async reads, x0 forced to zero
    assign rd1 = (addr1 == 5'd0) ? 32'h0 : regs[addr1];
    assign rd2 = (addr2 == 5'd0) ? 32'h0 : regs[addr2];

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu import riscv_ctrl_pkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  alu_op_e     alu_ctrl,
    output logic [31:0] alu_out,
    output logic [3:0]  alu_flags
);
    logic        sub_op;   // adder subtracts
    logic [31:0] b_eff;
    logic [32:0] sum;      // bit 32 is carry out
    logic        overflow;
    logic [4:0]  shamt;

    // compares reuse the subtractor
    assign sub_op = (alu_ctrl == alu_sub) || (alu_ctrl == alu_slt) || (alu_ctrl == alu_sltu);
    assign b_eff  = sub_op ? ~b : b;
    assign sum    = {1'b0, a} + {1'b0, b_eff} + {32'h0, sub_op};
    assign overflow = (a[31] == b_eff[31]) && (sum[31] != a[31]); // same-sign inputs flip
    assign shamt  = b[4:0];

    always_comb begin
        case (alu_ctrl)
            alu_add:  alu_out = sum[31:0];
            alu_sub:  alu_out = sum[31:0];
            alu_and:  alu_out = a & b;
            alu_or:   alu_out = a | b;
            alu_xor:  alu_out = a ^ b;
            alu_slt:  alu_out = {31'h0, sum[31] ^ overflow};
            alu_sltu: alu_out = {31'h0, ~sum[32]}; // no carry means borrow
            alu_sll:  alu_out = a << shamt;
            alu_srl:  alu_out = a >> shamt;
            alu_sra:  alu_out = $unsigned($signed(a) >>> shamt);
            default:  alu_out = 32'h0;
        endcase
    end

    assign alu_flags[flag_n] = alu_out[31];
    assign alu_flags[flag_z] = (alu_out == 32'h0);
    assign alu_flags[flag_c] = sum[32];   // from adder regardless of op
    assign alu_flags[flag_v] = overflow;

endmodule

// ==== verilog/datapath.sv ====
`timescale 1ns/1ps

module datapath import riscv_isa_pkg::*, riscv_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] instr,
    input  logic [31:0] read_data,
    input  logic        reg_we,
    input  imm_src_e    imm_src,
    input  alu_op_e     alu_ctrl,
    input  alu_src_e    alu_src,
    input  res_src_e    result_src,
    input  pc_src_e     pc_src,
    output logic [31:0] pc,
    output logic [31:0] alu_out,
    output logic [3:0]  alu_flags,
    output logic [31:0] write_data  // rs2, also store data
);
    logic [31:0] rs1;
    logic [31:0] ext_imm;
    logic [31:0] src_b;
    logic [31:0] wb_data;
    logic [31:0] pc_plus_4;
    logic [31:0] pc_next;

    assign pc_plus_4 = pc + 32'd4;

    // one instruction per edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= reset_pc;
        end else begin
            pc <= pc_next;
        end
    end

    always_comb begin
        case (pc_src)
            pc_src_plus_off:     pc_next = pc + ext_imm;
            pc_src_reg_plus_off: pc_next = (rs1 + ext_imm) & ~32'd1; // jalr clears bit 0
            default:             pc_next = pc_plus_4;
        endcase
    end

    regfile rf (
        .clk   (clk),
        .addr1 (instr[19:15]),
        .addr2 (instr[24:20]),
        .addr3 (instr[11:7]),
        .wd3   (wb_data),
        .we    (reg_we),
        .rd1   (rs1),
        .rd2   (write_data)
    );

    imm_extend ext (
        .instr   (instr),
        .imm_src (imm_src),
        .ext_imm (ext_imm)
    );

    assign src_b = (alu_src == alu_src_ext_imm) ? ext_imm : write_data;

    alu alu0 (
        .a         (rs1),
        .b         (src_b),
        .alu_ctrl  (alu_ctrl),
        .alu_out   (alu_out),
        .alu_flags (alu_flags)
    );

    always_comb begin
        case (result_src)
            res_src_read_data: wb_data = read_data;
            res_src_pc_plus_4: wb_data = pc_plus_4; // link value
            default:           wb_data = alu_out;
        endcase
    end

endmodule

// ==== verilog/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top import riscv_isa_pkg::*, riscv_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] instr,       // from instruction rom, same cycle
    input  logic [31:0] read_data,   // from data ram, same cycle
    output logic [31:0] instr_addr,
    output logic [31:0] data_addr,
    output logic [31:0] write_data,
    output logic        mem_we       // write lands on next rising edge
);
    logic       reg_we;
    logic [3:0] alu_flags;
    imm_src_e   imm_src;
    alu_op_e    alu_ctrl;
    alu_src_e   alu_src;
    res_src_e   result_src;
    pc_src_e    pc_src;

    control_decoder dec (
        .instr      (instr),
        .alu_flags  (alu_flags),
        .reg_we     (reg_we),
        .mem_we     (mem_we),
        .imm_src    (imm_src),
        .alu_ctrl   (alu_ctrl),
        .alu_src    (alu_src),
        .result_src (result_src),
        .pc_src     (pc_src)
    );

    datapath dp (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .read_data  (read_data),
        .reg_we     (reg_we),
        .imm_src    (imm_src),
        .alu_ctrl   (alu_ctrl),
        .alu_src    (alu_src),
        .result_src (result_src),
        .pc_src     (pc_src),
        .pc         (instr_addr),
        .alu_out    (data_addr),   // load/store address
        .alu_flags  (alu_flags),
        .write_data (write_data)
    );

endmodule

// ==== verif/tb_memory.sv ====
`timescale 1ns/1ps

module tb_memory (
    input  logic        clk,
    input  logic [31:0] instr_addr,
    output logic [31:0] instr,
    input  logic [31:0] data_addr,
    output logic [31:0] read_data,
    input  logic [31:0] write_data,
    input  logic        mem_we
);
    // 256 words each, byte addresses 0x000 to 0x3fc
    // contents are loaded by the testbench before reset
    logic [31:0] rom [256];
    logic [31:0] ram [256];

    // word index from a byte address
    function automatic logic [7:0] word_index(input logic [31:0] addr);
        word_index = addr[9:2];
    endfunction

    // fetch answers within the cycle
    assign instr = rom[word_index(instr_addr)];

    // load data, combinational
    assign read_data = ram[word_index(data_addr)];

    // store commits on the same edge as the pc update
    always @(posedge clk) begin
        if (mem_we) begin
            ram[word_index(data_addr)] <= write_data;
        end
    end

endmodule

// ==== verif/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb import riscv_isa_pkg::*, riscv_ctrl_pkg::*; ();
    logic        clk;
    logic        rst_n;
    logic [31:0] instr;
    logic [31:0] read_data;
    logic [31:0] instr_addr;
    logic [31:0] data_addr;
    logic [31:0] write_data;
    logic        mem_we;

    integer      seed;
    int          n;               // next rom word
    int          slot;            // next result word above 0x100
    logic [31:0] ops [8];         // random operands, ram words 0..7
    logic [31:0] exp_val [256];
    bit          exp_set [256];
    bit          seen [256];
    int          exp_cat [256];
    int          test_pass [6];
    int          test_fail [6];
    string       test_name [6];
    int          pass_cnt;
    int          fail_cnt;
    logic [31:0] link_exp;        // return address of the subroutine call
    logic [31:0] jalr_pc;
    logic [31:0] park_pc;         // jal-to-self
    bit          after_jalr;
    logic [7:0]  st_idx;

    localparam logic [31:0] marker = 32'h0000_0123;
    localparam logic [31:0] poison = 32'hffff_faab;

    cpu_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .instr      (instr),
        .read_data  (read_data),
        .instr_addr (instr_addr),
        .data_addr  (data_addr),
        .write_data (write_data),
        .mem_we     (mem_we)
    );

    tb_memory mem0 (
        .clk        (clk),
        .instr_addr (instr_addr),
        .instr      (instr),
        .data_addr  (data_addr),
        .read_data  (read_data),
        .write_data (write_data),
        .mem_we     (mem_we)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // instruction encoders with registers given as numbers
    function automatic logic [31:0] r_type(input logic [6:0] f7, input int rs2, input int rs1,
                                           input logic [2:0] f3, input int rd);
        r_type = {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], op_reg};
    endfunction

    function automatic logic [31:0] i_type(input logic [31:0] imm, input int rs1,
                                           input logic [2:0] f3, input int rd,
                                           input logic [6:0] op);
        i_type = {imm[11:0], rs1[4:0], f3, rd[4:0], op};
    endfunction

    function automatic logic [31:0] s_type(input logic [31:0] imm, input int rs2, input int rs1);
        s_type = {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], op_store}; // sw
    endfunction

    function automatic logic [31:0] b_type(input logic [31:0] imm, input int rs2, input int rs1,
                                           input logic [2:0] f3);
        b_type = {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [31:0] j_type(input logic [31:0] imm, input int rd);
        j_type = {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op_jal};
    endfunction

    // expected alu results straight from the isa rules
    function automatic logic [31:0] alu_ref(input logic [2:0] f3, input bit alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            f3_add:  alu_ref = alt ? a - b : a + b;
            f3_sll:  alu_ref = a << b[4:0];
            f3_slt:  alu_ref = {31'h0, $signed(a) < $signed(b)};
            f3_sltu: alu_ref = {31'h0, a < b};
            f3_xor:  alu_ref = a ^ b;
            f3_sr: begin
                if (alt) begin
                    alu_ref = $signed(a) >>> b[4:0]; // sign fill
                end else begin
                    alu_ref = a >> b[4:0];
                end
            end
            f3_or:   alu_ref = a | b;
            default: alu_ref = a & b;
        endcase
    endfunction

    function automatic bit br_ref(input logic [2:0] f3, input logic [31:0] a,
                                  input logic [31:0] b);
        case (f3)
            f3_beq:  br_ref = (a == b);
            f3_bne:  br_ref = (a != b);
            f3_blt:  br_ref = $signed(a) < $signed(b);
            f3_bge:  br_ref = $signed(a) >= $signed(b);
            f3_bltu: br_ref = a < b;
            default: br_ref = a >= b; // bgeu
        endcase
    endfunction

    task automatic emit(input logic [31:0] w);
        mem0.rom[n] = w;
        n++;
    endtask

    task automatic expect_store(input logic [31:0] addr, input logic [31:0] v, input int cat);
        exp_val[addr[9:2]] = v;
        exp_set[addr[9:2]] = 1'b1;
        exp_cat[addr[9:2]] = cat;
    endtask

    // sw rs2 into the next result word off x10
    task automatic store_result(input int rs2, input logic [31:0] v, input int cat);
        emit(s_type(slot * 4, rs2, 10));
        expect_store(32'h100 + slot * 4, v, cat);
        slot++;
    endtask

    task automatic note_pass(input int cat);
        pass_cnt++;
        test_pass[cat]++;
    endtask

    task automatic note_fail(input int cat);
        fail_cnt++;
        test_fail[cat]++;
    endtask

    // marker on the selected path and poison on the other one
    task automatic branch_case(input logic [2:0] f3, input int ra, input int rb,
                               input logic [31:0] a, input logic [31:0] b);
        bit taken;
        taken = br_ref(f3, a, b);
        emit(b_type(12, rb, ra, f3));
        emit(s_type(slot * 4, taken ? 31 : 30, 10)); // fall-through
        emit(j_type(8, 0));
        emit(s_type(slot * 4, taken ? 30 : 31, 10)); // target
        expect_store(32'h100 + slot * 4, marker, 3);
        slot++;
    endtask

    task automatic build_program();
        logic [31:0] imm;
        logic [2:0]  brs [6];
        brs = '{f3_beq, f3_bne, f3_blt, f3_bge, f3_bltu, f3_bgeu};
        emit(i_type(0, 0, f3_add, 0, op_imm));          // nop at reset_pc
        emit(i_type(0, 0, 3'b010, 1, op_load));         // lw x1, 0(x0)
        emit(i_type(4, 0, 3'b010, 2, op_load));         // lw x2, 4(x0)
        emit(i_type(32'h100, 0, f3_add, 10, op_imm));   // result base
        emit(i_type(32'h200, 0, f3_add, 11, op_imm));
        emit(i_type(marker, 0, f3_add, 30, op_imm));
        emit(i_type(poison, 0, f3_add, 31, op_imm));
        emit(i_type(32'hffff_ffff, 0, f3_add, 6, op_imm)); // x6 = -1
        emit(i_type(1, 0, f3_add, 7, op_imm));
        for (int f = 0; f < 8; f++) begin
            emit(r_type(7'h00, 2, 1, f[2:0], 4));
            store_result(4, alu_ref(f[2:0], 1'b0, ops[0], ops[1]), 1);
            if (f == 0 || f == 5) begin
                emit(r_type(7'h20, 2, 1, f[2:0], 4)); // sub, sra
                store_result(4, alu_ref(f[2:0], 1'b1, ops[0], ops[1]), 1);
            end
        end
        for (int f = 0; f < 8; f++) begin
            imm = $random(seed);
            imm = {{20{imm[11]}}, imm[11:0]};
            if (f == 1 || f == 5) begin
                imm = {27'h0, imm[4:0]}; // shamt only
            end
            emit(i_type(imm, 1, f[2:0], 4, op_imm));
            store_result(4, alu_ref(f[2:0], 1'b0, ops[0], imm), 1);
            if (f == 5) begin
                emit(i_type(imm | 32'h400, 1, f[2:0], 4, op_imm)); // srai
                store_result(4, alu_ref(f[2:0], 1'b1, ops[0], imm), 1);
            end
        end
        emit(i_type(12, 0, 3'b010, 8, op_load));        // lw x8, 12(x0)
        emit(s_type(32'hffff_fffc, 8, 11));             // sw x8, -4(x11)
        expect_store(32'h1fc, ops[3], 2);
        store_result(2, ops[1], 2);
        for (int i = 0; i < 6; i++) begin
            branch_case(brs[i], 1, 1, ops[0], ops[0]);
            branch_case(brs[i], 6, 7, 32'hffff_ffff, 32'h1);
            branch_case(brs[i], 1, 2, ops[0], ops[1]);
        end
        link_exp = n * 4 + 4;
        emit(j_type(12, 20));                            // call
        store_result(20, link_exp, 4);
        emit(j_type(12, 0));                             // hop over the subroutine
        emit(i_type(77, 0, f3_add, 21, op_imm));
        jalr_pc = n * 4;
        emit(i_type(0, 20, 3'b000, 0, op_jalr));         // return
        store_result(21, 32'd77, 4);
        emit(i_type(55, 0, f3_add, 0, op_imm));          // write to x0 dropped
        store_result(0, 32'h0, 5);
        park_pc = n * 4;
        emit(j_type(0, 0));
    endtask

    // store checker on every write strobe
    always @(posedge clk) begin
        if (rst_n && mem_we) begin
            st_idx = data_addr[9:2];
            assert (write_data != poison) else begin
                $display("poison value %h written to %h at %0t, wrong branch path taken",
                         write_data, data_addr, $time);
                note_fail(3);
            end
            if (data_addr[31:10] != 22'h0 || data_addr[1:0] != 2'b00 || !exp_set[st_idx]) begin
                $display("store to unexpected address %h at %0t", data_addr, $time);
                note_fail(2);
            end else begin
                seen[st_idx] = 1'b1;
                assert (write_data == exp_val[st_idx]) note_pass(exp_cat[st_idx]);
                else begin
                    $display("MISMATCH at %0t: write_data @%h expected %h got %h", $time,
                             data_addr, exp_val[st_idx], write_data);
                    note_fail(exp_cat[st_idx]);
                end
            end
        end
    end

    // reset state sampled on the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            assert (instr_addr == reset_pc) note_pass(0);
            else begin
                $display("MISMATCH at %0t: instr_addr expected %h got %h", $time, reset_pc,
                         instr_addr);
                note_fail(0);
            end
            assert (!mem_we) else begin
                $display("mem_we high during reset at %0t", $time);
                note_fail(0);
            end
        end
    end

    // jalr return target
    always @(posedge clk) begin
        if (rst_n) begin
            if (after_jalr) begin
                assert (instr_addr == link_exp) note_pass(4);
                else begin
                    $display("MISMATCH at %0t: instr_addr expected %h got %h", $time,
                             link_exp, instr_addr);
                    note_fail(4);
                end
            end
            after_jalr = (instr_addr == jalr_pc);
        end
    end

    initial begin
        int cycles;
        rst_n = 1'b0;
        seed = 32'h3bba;
        n = 0;
        slot = 0;
        pass_cnt = 0;
        fail_cnt = 0;
        after_jalr = 1'b0;
        test_name = '{"reset", "alu", "load/store", "branch", "jump", "x0"};
        for (int i = 0; i < 6; i++) begin
            test_pass[i] = 0;
            test_fail[i] = 0;
        end
        for (int i = 0; i < 256; i++) begin
            mem0.rom[i] = (i * 4) << 7;                    // opcode 0 unsupported, address above
            mem0.ram[i] = 32'h5a5a_0000 ^ (i * 4);         // tagged by byte address
            exp_set[i] = 1'b0;
            seen[i] = 1'b0;
        end
        for (int i = 0; i < 8; i++) begin
            ops[i] = $random(seed);
            mem0.ram[i] = ops[i];
        end
        build_program();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (instr_addr == reset_pc) note_pass(0);    // first edge after release
        else begin
            $display("MISMATCH at %0t: instr_addr expected %h got %h", $time, reset_pc,
                     instr_addr);
            note_fail(0);
        end
        $display("test %s done: %0d passed, %0d failed", test_name[0], test_pass[0],
                 test_fail[0]);
        cycles = 0;
        while (instr_addr != park_pc && cycles < 400) begin
            @(posedge clk);
            cycles++;
        end
        if (instr_addr != park_pc) begin
            $display("program never reached the final self-jump within 400 cycles");
            note_fail(4);
        end else begin
            for (int i = 0; i < 10; i++) begin
                @(posedge clk);
                assert (instr_addr == park_pc) else begin
                    $display("MISMATCH at %0t: instr_addr expected %h got %h", $time,
                             park_pc, instr_addr);
                    note_fail(4);
                end
            end
            for (int i = 0; i < 256; i++) begin
                if (exp_set[i] && !seen[i]) begin
                    $display("no store seen at address %h", i * 4);
                    note_fail(exp_cat[i]);
                end
            end
        end
        for (int t = 1; t < 6; t++) begin
            $display("test %s done: %0d passed, %0d failed", test_name[t], test_pass[t],
                     test_fail[t]);
        end
        $display("checks: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== all.f ====
verilog/riscv_isa_pkg.sv
verilog/riscv_ctrl_pkg.sv
verilog/control_decoder.sv
verilog/imm_extend.sv
verilog/regfile.sv
verilog/alu.sv
verilog/datapath.sv
verilog/cpu_top.sv
verif/tb_memory.sv
verif/cpu_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the cpu testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --top-module cpu_tb -f all.f -o cpu_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/cpu_sim > sim.log 2>&1 || { cat sim.log; echo "simulation error"; exit 1; }
cat sim.log
grep -q "Test FAILED" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q "Test OK" sim.log || { echo "no pass line in log"; exit 1; }
exit 0
